// File: logic/llc_consts.svh
`ifndef LLC_CONSTS_SVH
`define LLC_CONSTS_SVH

`define LLC_WAYS     4
`define LLC_SETS     16
`define LLC_SET_BITS 4   // set index width
`define LLC_WAY_BITS 2
`define LLC_TAG_BITS 8
`define LLC_CPUS     4   // requesters
`define LINE_BITS    128
`define ADDR_BITS    12  // line address, tag over set

`endif

// File: logic/llc_mem_pkg.sv
`include "llc_consts.svh"

package llc_mem_pkg;

    typedef logic [`LINE_BITS-1:0] line_t;
    typedef logic [`ADDR_BITS-1:0] line_addr_t;   // {tag, set}
    typedef logic [`LLC_TAG_BITS-1:0] llc_tag_t;
    typedef logic [`LLC_SET_BITS-1:0] llc_set_t;

endpackage

// File: logic/llc_coh_pkg.sv
`include "llc_consts.svh"

package llc_coh_pkg;

    typedef logic [`LLC_WAY_BITS-1:0] llc_way_t;
    typedef logic [$clog2(`LLC_CPUS)-1:0] owner_t;
    typedef logic [`LLC_CPUS-1:0] sharers_t;   // one bit per requester

    typedef enum logic [1:0] {
        INVALID  = 2'd0,
        SHARED   = 2'd1,
        MODIFIED = 2'd2
    } llc_state_t;

    typedef enum logic {
        GETS = 1'b0,
        GETM = 1'b1
    } req_op_t;

    typedef enum logic [2:0] {
        IDLE,
        READ_SET,
        LOOKUP,
        EVICT,
        FETCH,
        FILL,
        UPDATE,
        RESPOND
    } llc_ctrl_state_t;

endpackage

// File: logic/llc_set_mem.sv
`timescale 1ns/10ps
`include "llc_consts.svh"

module llc_set_mem (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     rd_en,
    input  logic                     wr_en,
    input  llc_mem_pkg::llc_set_t    set_idx,
    input  llc_mem_pkg::line_t       wr_data_line [`LLC_WAYS],
    input  llc_mem_pkg::llc_tag_t    wr_data_tag [`LLC_WAYS],
    input  llc_coh_pkg::llc_state_t wr_data_state [`LLC_WAYS],
    input  llc_coh_pkg::owner_t      wr_data_owner [`LLC_WAYS],
    input  llc_coh_pkg::sharers_t    wr_data_sharers [`LLC_WAYS],
    input  logic                     wr_data_dirty_bit [`LLC_WAYS],
    input  llc_coh_pkg::llc_way_t    wr_data_evict_way,
    output llc_mem_pkg::line_t       rd_data_line [`LLC_WAYS],
    output llc_mem_pkg::llc_tag_t    rd_data_tag [`LLC_WAYS],
    output llc_coh_pkg::llc_state_t  rd_data_state [`LLC_WAYS],
    output llc_coh_pkg::owner_t      rd_data_owner [`LLC_WAYS],
    output llc_coh_pkg::sharers_t    rd_data_sharers [`LLC_WAYS],
    output logic                     rd_data_dirty_bit [`LLC_WAYS],
    output llc_coh_pkg::llc_way_t    rd_data_evict_way
);

    llc_mem_pkg::line_t       mem_line [`LLC_SETS][`LLC_WAYS];
    llc_mem_pkg::llc_tag_t    mem_tag [`LLC_SETS][`LLC_WAYS];
    llc_coh_pkg::llc_state_t  mem_state [`LLC_SETS][`LLC_WAYS];
    llc_coh_pkg::owner_t      mem_owner [`LLC_SETS][`LLC_WAYS];
    llc_coh_pkg::sharers_t    mem_sharers [`LLC_SETS][`LLC_WAYS];
    logic                     mem_dirty [`LLC_SETS][`LLC_WAYS];
    llc_coh_pkg::llc_way_t    mem_evict [`LLC_SETS];

    // all sets start empty
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                mem_evict[s] <= '0;
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    mem_state[s][w] <= llc_coh_pkg::INVALID;
                    mem_dirty[s][w] <= 1'b0;
                end
            end
        end else if (wr_en) begin
            mem_evict[set_idx] <= wr_data_evict_way;
            for (int w = 0; w < `LLC_WAYS; w++) begin
                mem_state[set_idx][w] <= wr_data_state[w];
                mem_dirty[set_idx][w] <= wr_data_dirty_bit[w];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                mem_line[set_idx][w]    <= wr_data_line[w];
                mem_tag[set_idx][w]     <= wr_data_tag[w];
                mem_owner[set_idx][w]   <= wr_data_owner[w];
                mem_sharers[set_idx][w] <= wr_data_sharers[w];
            end
        end
        if (rd_en) begin   // whole set, one cycle later
            rd_data_evict_way <= mem_evict[set_idx];
            for (int w = 0; w < `LLC_WAYS; w++) begin
                rd_data_line[w]      <= mem_line[set_idx][w];
                rd_data_tag[w]       <= mem_tag[set_idx][w];
                rd_data_state[w]     <= mem_state[set_idx][w];
                rd_data_owner[w]     <= mem_owner[set_idx][w];
                rd_data_sharers[w]   <= mem_sharers[set_idx][w];
                rd_data_dirty_bit[w] <= mem_dirty[set_idx][w];
            end
        end
    end

endmodule

// File: logic/llc_set_bufs.sv
`timescale 1ns/10ps
`include "llc_consts.svh"

module llc_set_bufs (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     buf_clear,
    input  logic                     buf_load,
    input  logic                     incr_evict_way_buf,
    input  llc_coh_pkg::llc_way_t    way,
    input  logic                     mem_rsp_valid,
    input  logic                     mem_rsp_ready,
    input  llc_mem_pkg::line_t       mem_rsp_line,
    input  logic                     wr_en_lines_buf,
    input  logic                     wr_en_tags_buf,
    input  logic                     wr_en_states_buf,
    input  logic                     wr_en_owners_buf,
    input  logic                     wr_en_sharers_buf,
    input  logic                     wr_en_dirty_bits_buf,
    input  llc_mem_pkg::line_t       lines_buf_wr_data,
    input  llc_mem_pkg::llc_tag_t    tags_buf_wr_data,
    input  llc_coh_pkg::llc_state_t  states_buf_wr_data,
    input  llc_coh_pkg::owner_t      owners_buf_wr_data,
    input  llc_coh_pkg::sharers_t    sharers_buf_wr_data,
    input  logic                     dirty_bits_buf_wr_data,
    input  llc_mem_pkg::line_t       rd_data_line [`LLC_WAYS],
    input  llc_mem_pkg::llc_tag_t    rd_data_tag [`LLC_WAYS],
    input  llc_coh_pkg::llc_state_t  rd_data_state [`LLC_WAYS],
    input  llc_coh_pkg::owner_t      rd_data_owner [`LLC_WAYS],
    input  llc_coh_pkg::sharers_t    rd_data_sharers [`LLC_WAYS],
    input  logic                     rd_data_dirty_bit [`LLC_WAYS],
    input  llc_coh_pkg::llc_way_t    rd_data_evict_way,
    output llc_mem_pkg::line_t       lines_buf [`LLC_WAYS],
    output llc_mem_pkg::llc_tag_t    tags_buf [`LLC_WAYS],
    output llc_coh_pkg::llc_state_t  states_buf [`LLC_WAYS],
    output llc_coh_pkg::owner_t      owners_buf [`LLC_WAYS],
    output llc_coh_pkg::sharers_t    sharers_buf [`LLC_WAYS],
    output logic                     dirty_bits_buf [`LLC_WAYS],
    output llc_coh_pkg::llc_way_t    evict_way_buf
);

    logic fill_line;

    assign fill_line = mem_rsp_valid && mem_rsp_ready;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            evict_way_buf <= '0;
        end else if (buf_clear) begin
            evict_way_buf <= '0;
        end else if (buf_load) begin
            evict_way_buf <= rd_data_evict_way;
        end else if (incr_evict_way_buf) begin
            evict_way_buf <= evict_way_buf + 1'b1;   // wraps at the last way
        end
        for (int i = 0; i < `LLC_WAYS; i++) begin
            if (!rst) begin
                states_buf[i]     <= llc_coh_pkg::INVALID;
                dirty_bits_buf[i] <= 1'b0;
            end else if (buf_clear) begin
                states_buf[i]     <= llc_coh_pkg::INVALID;
                dirty_bits_buf[i] <= 1'b0;
            end else if (buf_load) begin
                states_buf[i]     <= rd_data_state[i];
                dirty_bits_buf[i] <= rd_data_dirty_bit[i];
            end else if (way == i) begin
                if (wr_en_states_buf)
                    states_buf[i] <= states_buf_wr_data;
                if (wr_en_dirty_bits_buf)
                    dirty_bits_buf[i] <= dirty_bits_buf_wr_data;
            end
        end
    end

    // payload fields
    always_ff @(posedge clk) begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            if (buf_clear) begin
                lines_buf[i]   <= '0;
                tags_buf[i]    <= '0;
                owners_buf[i]  <= '0;
                sharers_buf[i] <= '0;
            end else if (buf_load) begin
                lines_buf[i]   <= rd_data_line[i];
                tags_buf[i]    <= rd_data_tag[i];
                owners_buf[i]  <= rd_data_owner[i];
                sharers_buf[i] <= rd_data_sharers[i];
            end else if (way == i) begin
                if (fill_line)
                    lines_buf[i] <= mem_rsp_line;   // memory wins over field write
                else if (wr_en_lines_buf)
                    lines_buf[i] <= lines_buf_wr_data;
                if (wr_en_tags_buf)
                    tags_buf[i] <= tags_buf_wr_data;
                if (wr_en_owners_buf)
                    owners_buf[i] <= owners_buf_wr_data;
                if (wr_en_sharers_buf)
                    sharers_buf[i] <= sharers_buf_wr_data;
            end
        end
    end

endmodule

// File: logic/llc_way_select.sv
`timescale 1ns/10ps
`include "llc_consts.svh"

module llc_way_select (
    input  llc_mem_pkg::llc_tag_t    req_tag,
    input  llc_mem_pkg::llc_tag_t    tags_buf [`LLC_WAYS],
    input  llc_coh_pkg::llc_state_t  states_buf [`LLC_WAYS],
    output logic                     hit,
    output llc_coh_pkg::llc_way_t    hit_way,
    output llc_coh_pkg::llc_way_t    victim_way,
    output logic                     all_valid
);

    // scan downward so the lowest way is the last to win
    always_comb begin
        hit        = 1'b0;
        hit_way    = '0;
        victim_way = '0;
        all_valid  = 1'b1;
        for (int i = `LLC_WAYS - 1; i >= 0; i--) begin
            if (states_buf[i] == llc_coh_pkg::INVALID) begin
                victim_way = llc_coh_pkg::llc_way_t'(i);
                all_valid  = 1'b0;
            end else if (tags_buf[i] == req_tag) begin
                hit     = 1'b1;
                hit_way = llc_coh_pkg::llc_way_t'(i);
            end
        end
    end

endmodule

// File: logic/llc_ctrl.sv
`timescale 1ns/10ps
`include "llc_consts.svh"

module llc_ctrl (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        req_valid,
    input  llc_coh_pkg::req_op_t        req_op,
    input  llc_coh_pkg::owner_t         req_cpu,
    input  llc_mem_pkg::line_addr_t     req_addr,
    input  llc_mem_pkg::line_t          req_line,
    output logic                        req_ready,
    output logic                        rsp_valid,
    input  logic                        rsp_ready,
    output llc_mem_pkg::line_t          rsp_line,
    output logic                        rsp_hit,
    output llc_coh_pkg::llc_state_t     rsp_state,
    output llc_coh_pkg::sharers_t       rsp_sharers,
    output logic                        mem_req_valid,
    input  logic                        mem_req_ready,
    output logic                        mem_req_write,
    output llc_mem_pkg::line_addr_t     mem_req_addr,
    output llc_mem_pkg::line_t          mem_req_line,
    input  logic                        mem_rsp_valid,
    output logic                        mem_rsp_ready,
    input  logic                        hit,
    input  llc_coh_pkg::llc_way_t       hit_way,
    input  llc_coh_pkg::llc_way_t       victim_way,
    input  logic                        all_valid,
    input  llc_coh_pkg::llc_way_t       evict_way_buf,
    input  llc_mem_pkg::line_t          lines_buf [`LLC_WAYS],
    input  llc_mem_pkg::llc_tag_t       tags_buf [`LLC_WAYS],
    input  llc_coh_pkg::owner_t         owners_buf [`LLC_WAYS],
    input  llc_coh_pkg::sharers_t       sharers_buf [`LLC_WAYS],
    input  llc_coh_pkg::llc_state_t     states_buf [`LLC_WAYS],
    input  logic                        dirty_bits_buf [`LLC_WAYS],
    output logic                        set_rd_en,
    output logic                        set_wr_en,
    output llc_mem_pkg::llc_set_t       set_idx,
    output llc_mem_pkg::llc_tag_t       req_tag,
    output logic                        buf_clear,
    output logic                        buf_load,
    output logic                        incr_evict_way_buf,
    output llc_coh_pkg::llc_way_t       way,
    output logic                        wr_en_lines_buf,
    output logic                        wr_en_tags_buf,
    output logic                        wr_en_states_buf,
    output logic                        wr_en_owners_buf,
    output logic                        wr_en_sharers_buf,
    output logic                        wr_en_dirty_bits_buf,
    output llc_mem_pkg::line_t          lines_buf_wr_data,
    output llc_mem_pkg::llc_tag_t       tags_buf_wr_data,
    output llc_coh_pkg::llc_state_t     states_buf_wr_data,
    output llc_coh_pkg::owner_t         owners_buf_wr_data,
    output llc_coh_pkg::sharers_t       sharers_buf_wr_data,
    output logic                        dirty_bits_buf_wr_data
);

    llc_coh_pkg::llc_ctrl_state_t ctrl_state;
    logic                         phase;    // second step of LOOKUP, FETCH, RESPOND
    logic                         hit_r;
    llc_coh_pkg::llc_way_t        way_r;
    llc_coh_pkg::req_op_t         op_r;
    llc_coh_pkg::owner_t          cpu_r;
    llc_mem_pkg::line_addr_t      addr_r;
    llc_mem_pkg::line_t           line_r;
    llc_coh_pkg::sharers_t        cpu_bit;
    logic                         fill;
    logic                         upd;
    logic                         getm;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            ctrl_state <= llc_coh_pkg::IDLE;
            phase      <= 1'b0;
            hit_r      <= 1'b0;
            way_r      <= '0;
        end else begin
            case (ctrl_state)
                llc_coh_pkg::IDLE:
                    if (req_valid)
                        ctrl_state <= llc_coh_pkg::READ_SET;
                llc_coh_pkg::READ_SET: begin
                    ctrl_state <= llc_coh_pkg::LOOKUP;
                    phase      <= 1'b0;
                end
                llc_coh_pkg::LOOKUP:
                    if (!phase) begin
                        phase <= 1'b1;   // buffer loads this cycle
                    end else begin
                        phase <= 1'b0;
                        hit_r <= hit;
                        if (hit)
                            way_r <= hit_way;
                        else
                            way_r <= all_valid ? evict_way_buf : victim_way;
                        if (hit)
                            ctrl_state <= llc_coh_pkg::UPDATE;
                        else if (all_valid && dirty_bits_buf[evict_way_buf])
                            ctrl_state <= llc_coh_pkg::EVICT;
                        else
                            ctrl_state <= llc_coh_pkg::FETCH;
                    end
                llc_coh_pkg::EVICT:
                    if (mem_req_ready)
                        ctrl_state <= llc_coh_pkg::FETCH;
                llc_coh_pkg::FETCH:
                    if (!phase) begin
                        if (mem_req_ready)
                            phase <= 1'b1;
                    end else if (mem_rsp_valid) begin
                        phase      <= 1'b0;
                        ctrl_state <= llc_coh_pkg::FILL;
                    end
                llc_coh_pkg::FILL:
                    ctrl_state <= llc_coh_pkg::UPDATE;
                llc_coh_pkg::UPDATE:
                    ctrl_state <= llc_coh_pkg::RESPOND;
                llc_coh_pkg::RESPOND:
                    if (!phase) begin
                        phase <= 1'b1;   // set written back here
                    end else if (rsp_ready) begin
                        phase      <= 1'b0;
                        ctrl_state <= llc_coh_pkg::IDLE;
                    end
                default:
                    ctrl_state <= llc_coh_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid && req_ready) begin
            op_r   <= req_op;
            cpu_r  <= req_cpu;
            addr_r <= req_addr;
            line_r <= req_line;
        end
    end

    assign req_ready          = ctrl_state == llc_coh_pkg::IDLE;
    assign buf_clear          = req_valid && req_ready;
    assign set_rd_en          = ctrl_state == llc_coh_pkg::READ_SET;
    assign buf_load           = ctrl_state == llc_coh_pkg::LOOKUP && !phase;
    assign incr_evict_way_buf = ctrl_state == llc_coh_pkg::LOOKUP && phase && !hit && all_valid;
    assign set_wr_en          = ctrl_state == llc_coh_pkg::RESPOND && !phase;
    assign set_idx            = addr_r[`LLC_SET_BITS-1:0];
    assign req_tag            = addr_r[`ADDR_BITS-1 -: `LLC_TAG_BITS];
    assign way                = way_r;

    assign mem_req_write = ctrl_state == llc_coh_pkg::EVICT;
    assign mem_req_valid = mem_req_write || (ctrl_state == llc_coh_pkg::FETCH && !phase);
    assign mem_req_addr  = mem_req_write ? {tags_buf[way_r], set_idx} : addr_r;
    assign mem_req_line  = lines_buf[way_r];   // victim line on write-back
    assign mem_rsp_ready = ctrl_state == llc_coh_pkg::FETCH && phase;

    assign rsp_valid   = ctrl_state == llc_coh_pkg::RESPOND && phase;
    assign rsp_line    = lines_buf[way_r];
    assign rsp_hit     = hit_r;
    assign rsp_state   = states_buf[way_r];
    assign rsp_sharers = sharers_buf[way_r];

    assign fill = ctrl_state == llc_coh_pkg::FILL;
    assign upd  = ctrl_state == llc_coh_pkg::UPDATE;
    assign getm = op_r == llc_coh_pkg::GETM;

    assign wr_en_lines_buf      = upd && getm;
    assign wr_en_tags_buf       = fill;
    assign wr_en_states_buf     = fill || upd;
    assign wr_en_owners_buf     = fill || (upd && getm);
    assign wr_en_sharers_buf    = fill || upd;
    assign wr_en_dirty_bits_buf = fill || (upd && getm);

    assign lines_buf_wr_data      = line_r;
    assign tags_buf_wr_data       = req_tag;
    assign owners_buf_wr_data     = fill ? '0 : cpu_r;
    assign dirty_bits_buf_wr_data = upd;
    assign cpu_bit                = llc_coh_pkg::sharers_t'(1) << cpu_r;

    // fresh line starts INVALID so UPDATE sees no old sharers
    always_comb begin
        if (fill) begin
            states_buf_wr_data  = llc_coh_pkg::INVALID;
            sharers_buf_wr_data = '0;
        end else if (getm) begin
            states_buf_wr_data  = llc_coh_pkg::MODIFIED;
            sharers_buf_wr_data = '0;
        end else begin
            states_buf_wr_data = llc_coh_pkg::SHARED;
            if (states_buf[way_r] == llc_coh_pkg::MODIFIED)
                sharers_buf_wr_data = (llc_coh_pkg::sharers_t'(1) << owners_buf[way_r]) | cpu_bit;
            else
                sharers_buf_wr_data = sharers_buf[way_r] | cpu_bit;
        end
    end

endmodule

// File: logic/llc_top.sv
`timescale 1ns/10ps
`include "llc_consts.svh"

module llc_top (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     req_valid,
    input  llc_coh_pkg::req_op_t     req_op,
    input  llc_coh_pkg::owner_t      req_cpu,
    input  llc_mem_pkg::line_addr_t  req_addr,
    input  llc_mem_pkg::line_t       req_line,
    output logic                     req_ready,
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output llc_mem_pkg::line_t       rsp_line,
    output logic                     rsp_hit,
    output llc_coh_pkg::llc_state_t  rsp_state,
    output llc_coh_pkg::sharers_t    rsp_sharers,
    output logic                     mem_req_valid,
    input  logic                     mem_req_ready,
    output logic                     mem_req_write,
    output llc_mem_pkg::line_addr_t  mem_req_addr,
    output llc_mem_pkg::line_t       mem_req_line,
    input  logic                     mem_rsp_valid,
    output logic                     mem_rsp_ready,
    input  llc_mem_pkg::line_t       mem_rsp_line
);

    logic                     set_rd_en;
    logic                     set_wr_en;
    llc_mem_pkg::llc_set_t    set_idx;
    llc_mem_pkg::llc_tag_t    req_tag;
    logic                     buf_clear;
    logic                     buf_load;
    logic                     incr_evict_way_buf;
    llc_coh_pkg::llc_way_t    way;
    logic                     hit;
    logic                     all_valid;
    llc_coh_pkg::llc_way_t    hit_way;
    llc_coh_pkg::llc_way_t    victim_way;

    logic                     wr_en_lines_buf;
    logic                     wr_en_tags_buf;
    logic                     wr_en_states_buf;
    logic                     wr_en_owners_buf;
    logic                     wr_en_sharers_buf;
    logic                     wr_en_dirty_bits_buf;
    llc_mem_pkg::line_t       lines_buf_wr_data;
    llc_mem_pkg::llc_tag_t    tags_buf_wr_data;
    llc_coh_pkg::llc_state_t  states_buf_wr_data;
    llc_coh_pkg::owner_t      owners_buf_wr_data;
    llc_coh_pkg::sharers_t    sharers_buf_wr_data;
    logic                     dirty_bits_buf_wr_data;

    // set memory read port
    llc_mem_pkg::line_t       rd_data_line [`LLC_WAYS];
    llc_mem_pkg::llc_tag_t    rd_data_tag [`LLC_WAYS];
    llc_coh_pkg::llc_state_t  rd_data_state [`LLC_WAYS];
    llc_coh_pkg::owner_t      rd_data_owner [`LLC_WAYS];
    llc_coh_pkg::sharers_t    rd_data_sharers [`LLC_WAYS];
    logic                     rd_data_dirty_bit [`LLC_WAYS];
    llc_coh_pkg::llc_way_t    rd_data_evict_way;

    // buffered set
    llc_mem_pkg::line_t       lines_buf [`LLC_WAYS];
    llc_mem_pkg::llc_tag_t    tags_buf [`LLC_WAYS];
    llc_coh_pkg::llc_state_t  states_buf [`LLC_WAYS];
    llc_coh_pkg::owner_t      owners_buf [`LLC_WAYS];
    llc_coh_pkg::sharers_t    sharers_buf [`LLC_WAYS];
    logic                     dirty_bits_buf [`LLC_WAYS];
    llc_coh_pkg::llc_way_t    evict_way_buf;

    llc_ctrl u_ctrl (.*);

    llc_set_mem u_set_mem (
        .clk               (clk),
        .rst               (rst),
        .rd_en             (set_rd_en),
        .wr_en             (set_wr_en),
        .set_idx           (set_idx),
        .wr_data_line      (lines_buf),
        .wr_data_tag       (tags_buf),
        .wr_data_state     (states_buf),
        .wr_data_owner     (owners_buf),
        .wr_data_sharers   (sharers_buf),
        .wr_data_dirty_bit (dirty_bits_buf),
        .wr_data_evict_way (evict_way_buf),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_state     (rd_data_state),
        .rd_data_owner     (rd_data_owner),
        .rd_data_sharers   (rd_data_sharers),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_evict_way (rd_data_evict_way)
    );

    llc_set_bufs u_set_bufs (.*);

    llc_way_select u_way_select (
        .req_tag    (req_tag),
        .tags_buf   (tags_buf),
        .states_buf (states_buf),
        .hit        (hit),
        .hit_way    (hit_way),
        .victim_way (victim_way),
        .all_valid  (all_valid)
    );

endmodule

// File: verification/llc_tb.sv
`timescale 1ns/10ps

module llc_tb;

    localparam int FIELDS     = 11;    // words per request in the stimulus file
    localparam int MAX_REQS   = 40;
    localparam int WAIT_LIMIT = 200;   // cycles

    logic                     clk;
    logic                     rst;
    logic                     req_valid;
    llc_coh_pkg::req_op_t     req_op;
    llc_coh_pkg::owner_t      req_cpu;
    llc_mem_pkg::line_addr_t  req_addr;
    llc_mem_pkg::line_t       req_line;
    logic                     req_ready;
    logic                     rsp_valid;
    logic                     rsp_ready;
    llc_mem_pkg::line_t       rsp_line;
    logic                     rsp_hit;
    llc_coh_pkg::llc_state_t  rsp_state;
    llc_coh_pkg::sharers_t    rsp_sharers;
    logic                     mem_req_valid;
    logic                     mem_req_ready = 1'b0;
    logic                     mem_req_write;
    llc_mem_pkg::line_addr_t  mem_req_addr;
    llc_mem_pkg::line_t       mem_req_line;
    logic                     mem_rsp_valid = 1'b0;
    logic                     mem_rsp_ready;
    llc_mem_pkg::line_t       mem_rsp_line = '0;

    logic [127:0]             vec [FIELDS*MAX_REQS];
    int                       n_reqs;
    logic [31:0]              drv_rng;

    // memory model state
    logic [31:0]              mem_rng = 32'he19a_71d0;
    logic                     fetch_pending = 1'b0;
    logic                     rsp_taken = 1'b0;
    llc_mem_pkg::line_addr_t  fetch_addr = '0;
    logic [1:0]               fetch_delay = '0;
    int                       wb_count = 0;
    llc_mem_pkg::line_addr_t  wb_addr = '0;
    llc_mem_pkg::line_t       wb_line = '0;

    llc_top UUT (.*);

    always #20 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // address repeated in 16-bit chunks, xored with a fixed pattern
    function automatic llc_mem_pkg::line_t mem_line_for(input llc_mem_pkg::line_addr_t a);
        return {8{4'h0, a}} ^ {8{16'hc000}};
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
            abort_run($sformatf("CHECK FAILED at %0t: %s is %h, expected %h",
                                $time, name, got, exp));
    endtask

    // memory side, reacts on falling edges
    always @(negedge clk) begin
        if (rst) begin
            mem_rng = xorshift32(mem_rng);
            if (rsp_taken) begin
                mem_rsp_valid = 1'b0;
                rsp_taken     = 1'b0;
            end
            if (fetch_pending && !mem_rsp_valid) begin
                if (fetch_delay == 0) begin
                    mem_rsp_valid = 1'b1;
                    mem_rsp_line  = mem_line_for(fetch_addr);
                    fetch_pending = 1'b0;
                end else begin
                    fetch_delay = fetch_delay - 1'b1;
                end
            end
            if (mem_rsp_valid && mem_rsp_ready)
                rsp_taken = 1'b1;   // line taken at the coming edge
            mem_req_ready = mem_req_valid && mem_rng[0];
            if (mem_req_ready) begin
                if (mem_req_write) begin
                    wb_count++;
                    wb_addr = mem_req_addr;
                    wb_line = mem_req_line;
                end else begin
                    fetch_pending = 1'b1;
                    fetch_addr    = mem_req_addr;
                    fetch_delay   = mem_rng[5:4];
                end
            end
        end
    end

    task automatic run_request(input int r);
        int   base;
        int   waited;
        int   latency;
        int   wb_before;
        logic taken;
        base      = r * FIELDS;
        wb_before = wb_count;
        req_valid = 1'b1;
        req_op    = llc_coh_pkg::req_op_t'(vec[base][0]);
        req_cpu   = llc_coh_pkg::owner_t'(vec[base+1]);
        req_addr  = llc_mem_pkg::line_addr_t'(vec[base+2]);
        req_line  = vec[base+3];
        waited    = 0;
        while (!req_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run($sformatf("request %0d was never accepted", r));
        end
        @(negedge clk);   // handshake on the edge in between
        req_valid = 1'b0;
        latency   = 0;
        while (!rsp_valid) begin
            @(negedge clk);
            latency++;
            if (latency > WAIT_LIMIT)
                abort_run($sformatf("no response to request %0d", r));
        end
        if (vec[base+5][0])
            check_value("rsp_valid latency", latency, 5);   // fixed hit path
        taken  = 1'b0;
        waited = 0;
        while (!taken) begin
            check_value("rsp_valid", rsp_valid, 1'b1);
            check_value("req_ready", req_ready, 1'b0);   // busy until the response is taken
            check_value("rsp_line", rsp_line, vec[base+4]);
            check_value("rsp_hit", rsp_hit, vec[base+5][0]);
            check_value("rsp_state", rsp_state, vec[base+6][1:0]);
            check_value("rsp_sharers", rsp_sharers, vec[base+7][3:0]);
            drv_rng   = xorshift32(drv_rng);
            rsp_ready = drv_rng[0] | drv_rng[1];   // ready about 3 cycles in 4
            taken     = rsp_ready;
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT)
                abort_run($sformatf("response %0d was never taken", r));
        end
        rsp_ready = 1'b0;
        check_value("rsp_valid", rsp_valid, 1'b0);   // no second response
        check_value("write-back count", wb_count - wb_before, vec[base+8]);
        if (vec[base+8][0]) begin
            check_value("mem_req_addr", wb_addr, vec[base+9]);
            check_value("mem_req_line", wb_line, vec[base+10]);
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       = 1'b0;
        req_valid = 1'b0;
        req_op    = llc_coh_pkg::GETS;
        req_cpu   = '0;
        req_addr  = '0;
        req_line  = '0;
        rsp_ready = 1'b0;
        drv_rng   = 32'he19a_71d0;
        for (int i = 0; i < FIELDS*MAX_REQS; i++)
            vec[i] = '1;   // all ones ends the list
        $readmemh("verification/llc_input.txt", vec);
        n_reqs = 0;
        while (n_reqs < MAX_REQS && vec[n_reqs*FIELDS] !== '1)
            n_reqs++;
        if (n_reqs == 0)
            abort_run("no requests found in verification/llc_input.txt");

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b1;
        @(negedge clk);
        check_value("req_ready", req_ready, 1'b1);
        check_value("rsp_valid", rsp_valid, 1'b0);
        check_value("mem_req_valid", mem_req_valid, 1'b0);
        check_value("mem_rsp_ready", mem_rsp_ready, 1'b0);

        for (int r = 0; r < n_reqs; r++)
            run_request(r);

        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// File: verification/llc_input.txt
// op(0 GETS, 1 GETM) cpu addr req_line, expected rsp_line hit state(1 S, 2 M) sharers,
// then expected write-back count, write-back address and write-back line
0 0 013 0 c013c013c013c013c013c013c013c013 0 1 1 0 0 0
0 2 013 0 c013c013c013c013c013c013c013c013 1 1 5 0 0 0
1 1 013 0123456789abcdef0011223344556677 0123456789abcdef0011223344556677 1 2 0 0 0 0
0 3 013 0 0123456789abcdef0011223344556677 1 1 a 0 0 0
1 2 023 fedcba98765432100f1e2d3c4b5a6978 fedcba98765432100f1e2d3c4b5a6978 0 2 0 0 0 0
1 0 105 a0a0a0a0111122223333444455556666 a0a0a0a0111122223333444455556666 0 2 0 0 0 0
0 1 115 0 c115c115c115c115c115c115c115c115 0 1 2 0 0 0
1 2 125 a2a2a2a2777788889999aaaabbbbcccc a2a2a2a2777788889999aaaabbbbcccc 0 2 0 0 0 0
0 3 135 0 c135c135c135c135c135c135c135c135 0 1 8 0 0 0
0 0 145 0 c145c145c145c145c145c145c145c145 0 1 1 1 105 a0a0a0a0111122223333444455556666
0 1 155 0 c155c155c155c155c155c155c155c155 0 1 2 0 0 0
0 2 165 0 c165c165c165c165c165c165c165c165 0 1 4 1 125 a2a2a2a2777788889999aaaabbbbcccc
1 3 175 a3a3a3a3ddddeeeeffff000011112222 a3a3a3a3ddddeeeeffff000011112222 0 2 0 0 0 0
0 1 185 0 c185c185c185c185c185c185c185c185 0 1 2 0 0 0
0 0 175 0 a3a3a3a3ddddeeeeffff000011112222 1 1 9 0 0 0
0 2 155 0 c155c155c155c155c155c155c155c155 1 1 6 0 0 0
0 0 195 0 c195c195c195c195c195c195c195c195 0 1 1 0 0 0
0 1 1a5 0 c1a5c1a5c1a5c1a5c1a5c1a5c1a5c1a5 0 1 2 0 0 0
0 2 1b5 0 c1b5c1b5c1b5c1b5c1b5c1b5c1b5c1b5 0 1 4 1 175 a3a3a3a3ddddeeeeffff000011112222
0 3 105 0 c105c105c105c105c105c105c105c105 0 1 8 0 0 0
0 0 023 0 fedcba98765432100f1e2d3c4b5a6978 1 1 5 0 0 0
0 1 013 0 0123456789abcdef0011223344556677 1 1 a 0 0 0
1 3 000 3333333300000000cafef00d12345678 3333333300000000cafef00d12345678 0 2 0 0 0 0
1 0 000 4444444455555555deadbeef87654321 4444444455555555deadbeef87654321 1 2 0 0 0 0
0 1 000 0 4444444455555555deadbeef87654321 1 1 3 0 0 0
0 2 fff 0 cfffcfffcfffcfffcfffcfffcfffcfff 0 1 4 0 0 0

// File: src.f
+incdir+logic
logic/llc_mem_pkg.sv
logic/llc_coh_pkg.sv
logic/llc_set_mem.sv
logic/llc_set_bufs.sv
logic/llc_way_select.sv
logic/llc_ctrl.sv
logic/llc_top.sv
verification/llc_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal -f src.f --top-module llc_tb -o llc_sim
./obj_dir/llc_sim
